// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= leaf_node_tb
FILELIST  ?= leaf_node.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0
SIM_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== leaf_node.f ====
rtl/leaf_pkg.sv
rtl/cfg_wr_if.sv
rtl/packet_rx.sv
rtl/stream_fifo.sv
rtl/start_timer.sv
rtl/packet_tx.sv
rtl/user_kernel.sv
rtl/leaf_node.sv
verif/tb_clock.sv
verif/leaf_node_asserts.sv
verif/leaf_node_tb.sv

// ==== rtl/cfg_wr_if.sv ====
`timescale 1ns/1ns
interface cfg_wr_if
    import leaf_pkg::*;
();

    logic                 we;    // one-cycle write strobe
    logic                 sel;   // output stream whose entry is written
    logic [leaf_bits-1:0] leaf;
    logic [port_bits-1:0] port;

    modport source (
        output we, sel, leaf, port
    );

    modport sink (
        input we, sel, leaf, port
    );

endinterface

// ==== rtl/leaf_node.sv ====
`timescale 1ns/1ns
module leaf_node
    import leaf_pkg::*;
#(
    parameter int fifo_depth = 8,
    parameter int start_hold = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [packet_bits-1:0] din,
    output logic [packet_bits-1:0] dout,
    input  logic                   resend,
    input  logic                   ap_start,
    output logic                   overflow
);

    logic [3:0]                   push;
    logic [3:0][payload_bits-1:0] push_data;
    logic [3:0]                   full;
    logic [3:0]                   in_vld;
    logic [3:0][payload_bits-1:0] in_data;
    logic [3:0]                   in_ack;
    logic [1:0]                   out_vld;
    logic [1:0][payload_bits-1:0] out_data;
    logic [1:0]                   out_ack;
    logic                         user_rst_n;

    cfg_wr_if cfg_bus ();

    packet_rx packet_rx_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .din       (din),
        .cfg       (cfg_bus.source),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .overflow  (overflow)
    );

    for (genvar i = 0; i < 4; i++) begin : g_fifo
        stream_fifo #(
            .fifo_depth (fifo_depth)
        ) fifo_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (push[i]),
            .push_data (push_data[i]),
            .full      (full[i]),
            .vld       (in_vld[i]),
            .ack       (in_ack[i]),
            .data      (in_data[i])
        );
    end

    start_timer #(
        .start_hold (start_hold)
    ) start_timer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ap_start   (ap_start),
        .user_rst_n (user_rst_n)
    );

    user_kernel user_kernel_inst (
        .clk        (clk),
        .user_rst_n (user_rst_n),
        .in_vld     (in_vld),
        .in_data    (in_data),
        .in_ack     (in_ack),
        .out_vld    (out_vld),
        .out_data   (out_data),
        .out_ack    (out_ack)
    );

    packet_tx packet_tx_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfg    (cfg_bus.sink),
        .s_vld  (out_vld),
        .s_data (out_data),
        .s_ack  (out_ack),
        .resend (resend),
        .dout   (dout)
    );

endmodule

// ==== rtl/leaf_pkg.sv ====
package leaf_pkg;

    localparam int packet_bits  = 49;
    localparam int payload_bits = 32;
    localparam int leaf_bits    = 5;
    localparam int port_bits    = 4;
    localparam int addr_bits    = 7;

    // field offsets, payload at the bottom and the valid bit on top
    localparam int payload_lo    = 0;
    localparam int payload_hi    = payload_lo + payload_bits - 1;
    localparam int addr_lo       = payload_hi + 1;
    localparam int addr_hi       = addr_lo + addr_bits - 1;
    localparam int port_lo       = addr_hi + 1;
    localparam int port_hi       = port_lo + port_bits - 1;
    localparam int leaf_lo       = port_hi + 1;
    localparam int leaf_hi       = leaf_lo + leaf_bits - 1;
    localparam int pkt_valid_pos = leaf_hi + 1;

    // layout of a configuration payload on port 0
    localparam int cfg_op_hi   = 31;
    localparam int cfg_op_lo   = 28;
    localparam int cfg_port_hi = 15;
    localparam int cfg_port_lo = 12;
    localparam int cfg_sel_pos = 8;
    localparam int cfg_leaf_hi = 4;
    localparam int cfg_leaf_lo = 0;

    typedef enum logic [3:0] {
        cfg_nop      = 4'd0,
        cfg_set_dest = 4'd1  // writes one entry of the destination table
    } cfg_op_e;

    typedef enum logic [1:0] {
        tx_idle,
        tx_send,
        tx_hold  // packet pending while the tree asks for resend
    } tx_state_e;

endpackage

// ==== rtl/packet_rx.sv ====
`timescale 1ns/1ns
module packet_rx
    import leaf_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [packet_bits-1:0]       din,
    cfg_wr_if.source                     cfg,
    output logic [3:0]                   push,
    output logic [3:0][payload_bits-1:0] push_data,
    input  logic [3:0]                   full,
    output logic                         overflow
);

    logic                    pkt_vld;
    logic [port_bits-1:0]    dst_port;
    logic [payload_bits-1:0] payload;
    cfg_op_e                 op;
    logic [3:0]              push_d;
    logic                    cfg_d;

    assign pkt_vld  = din[pkt_valid_pos];
    assign dst_port = din[port_hi:port_lo];
    assign payload  = din[payload_hi:payload_lo];
    assign op       = cfg_op_e'(payload[cfg_op_hi:cfg_op_lo]);

    always_comb begin
        cfg_d = 1'b0;
        if (pkt_vld && dst_port == '0) begin
            case (op)
                cfg_set_dest: cfg_d = 1'b1;
                default:      cfg_d = 1'b0;  // nop and unknown opcodes do nothing
            endcase
        end
        // ports 1 to 4 map onto buffers 0 to 3, anything higher is dropped quietly
        for (int i = 0; i < 4; i++) begin
            push_d[i] = pkt_vld && (dst_port == port_bits'(i + 1));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push     <= '0;
            cfg.we   <= 1'b0;
            overflow <= 1'b0;
        end else begin
            push   <= push_d;
            cfg.we <= cfg_d;
            if (|(push & full)) begin
                overflow <= 1'b1;  // the buffer refuses this word, flag stays until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (push_d[i]) begin
                push_data[i] <= payload;
            end
        end
        if (cfg_d) begin
            cfg.sel  <= payload[cfg_sel_pos];
            cfg.leaf <= payload[cfg_leaf_hi:cfg_leaf_lo];
            cfg.port <= payload[cfg_port_hi:cfg_port_lo];
        end
    end

endmodule

// ==== rtl/packet_tx.sv ====
`timescale 1ns/1ns
module packet_tx
    import leaf_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    cfg_wr_if.sink                       cfg,
    input  logic [1:0]                   s_vld,
    input  logic [1:0][payload_bits-1:0] s_data,
    output logic [1:0]                   s_ack,
    input  logic                         resend,
    output logic [packet_bits-1:0]       dout
);

    tx_state_e              state;
    logic                   rr;     // stream that wins the next tie
    logic                   pick;
    logic                   grant;
    logic [packet_bits-1:0] pkt_d;
    logic [packet_bits-1:0] pkt_q;
    logic [leaf_bits-1:0]   dest_leaf [2];
    logic [port_bits-1:0]   dest_port [2];

    assign pick  = s_vld[rr] ? rr : !rr;
    assign grant = (state == tx_idle) && !resend && (|s_vld);
    assign s_ack = grant ? (pick ? 2'b10 : 2'b01) : 2'b00;
    assign dout  = (state == tx_send && !resend) ? pkt_q : '0;

    always_comb begin
        pkt_d                        = '0;
        pkt_d[pkt_valid_pos]         = 1'b1;
        pkt_d[leaf_hi:leaf_lo]       = dest_leaf[pick];
        pkt_d[port_hi:port_lo]       = dest_port[pick];
        pkt_d[addr_hi:addr_lo]       = '0;  // no addressing inside the far kernel yet
        pkt_d[payload_hi:payload_lo] = s_data[pick];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= tx_idle;
            rr    <= 1'b0;
        end else begin
            case (state)
                tx_idle: begin
                    if (grant) begin
                        state <= tx_send;
                        rr    <= !pick;
                    end
                end
                tx_send: state <= resend ? tx_hold : tx_idle;
                tx_hold: begin
                    if (!resend) begin
                        state <= tx_send;  // replay the held packet
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2; i++) begin
                dest_leaf[i] <= '0;
                dest_port[i] <= '0;
            end
        end else if (cfg.we) begin
            dest_leaf[cfg.sel] <= cfg.leaf;
            dest_port[cfg.sel] <= cfg.port;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            pkt_q <= pkt_d;
        end
    end

endmodule

// ==== rtl/start_timer.sv ====
`timescale 1ns/1ns
module start_timer #(
    parameter int start_hold = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic ap_start,
    output logic user_rst_n
);

    localparam int cnt_bits = $clog2(start_hold + 1);

    logic [cnt_bits-1:0] cnt;

    // kernel stays in reset until the first ap_start has counted down
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= '0;
            user_rst_n <= 1'b0;
        end else if (ap_start) begin
            cnt        <= cnt_bits'(start_hold);  // a repeated start reloads the count
            user_rst_n <= 1'b0;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
            if (cnt == cnt_bits'(1)) begin
                user_rst_n <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/stream_fifo.sv ====
`timescale 1ns/1ns
module stream_fifo
    import leaf_pkg::*;
#(
    parameter int fifo_depth = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  logic [payload_bits-1:0] push_data,
    output logic                    full,
    output logic                    vld,
    input  logic                    ack,
    output logic [payload_bits-1:0] data
);

    localparam int ptr_bits = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

    logic [payload_bits-1:0] mem [fifo_depth];
    logic [ptr_bits-1:0]     wr_ptr;
    logic [ptr_bits-1:0]     rd_ptr;
    logic [ptr_bits:0]       count;
    logic                    wr_en;
    logic                    rd_en;

    assign full  = (count == (ptr_bits + 1)'(fifo_depth));
    assign vld   = (count != '0);
    assign data  = mem[rd_ptr];
    assign wr_en = push && !full;  // a push into a full buffer is lost
    assign rd_en = vld && ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_bits'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_bits'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== rtl/user_kernel.sv ====
`timescale 1ns/1ns
module user_kernel
    import leaf_pkg::*;
(
    input  logic                         clk,
    input  logic                         user_rst_n,
    input  logic [3:0]                   in_vld,
    input  logic [3:0][payload_bits-1:0] in_data,
    output logic [3:0]                   in_ack,
    output logic [1:0]                   out_vld,
    output logic [1:0][payload_bits-1:0] out_data,
    input  logic [1:0]                   out_ack
);

    logic run;  // low until the first clock after the user reset releases

    always_ff @(posedge clk or negedge user_rst_n) begin
        if (!user_rst_n) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // output 0 adds inputs 0 and 1, output 1 xors inputs 2 and 3
    for (genvar g = 0; g < 2; g++) begin : g_out
        logic                    take;
        logic                    vld_q;
        logic [payload_bits-1:0] data_q;
        logic [payload_bits-1:0] a;
        logic [payload_bits-1:0] b;

        assign a    = in_data[2*g];
        assign b    = in_data[2*g+1];
        assign take = run && in_vld[2*g] && in_vld[2*g+1] && (!vld_q || out_ack[g]);

        assign in_ack[2*g]   = take;  // both words of a pair leave together
        assign in_ack[2*g+1] = take;
        assign out_vld[g]    = vld_q;
        assign out_data[g]   = data_q;

        always_ff @(posedge clk or negedge user_rst_n) begin
            if (!user_rst_n) begin
                vld_q <= 1'b0;
            end else if (take) begin
                vld_q <= 1'b1;
            end else if (out_ack[g]) begin
                vld_q <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (take) begin
                data_q <= (g == 0) ? a + b : a ^ b;
            end
        end
    end

endmodule

// ==== verif/leaf_node_asserts.sv ====
`timescale 1ns/1ns
module leaf_node_asserts
    import leaf_pkg::*;
(
    input logic                   clk,
    input logic                   rst_n,
    input logic [packet_bits-1:0] dout,
    input logic                   resend,
    input logic                   overflow
);

    int fail_count = 0;

    assert property (@(posedge clk) disable iff (!rst_n) resend |-> dout == '0)
    else begin
        fail_count++;
        $error("dout carried data while resend was high");
    end

    // the transmitter passes through tx_idle between packets, so the bus is idle first
    assert property (@(posedge clk) disable iff (!rst_n)
        dout[pkt_valid_pos] |-> !$past(dout[pkt_valid_pos]))
    else begin
        fail_count++;
        $error("a packet on dout did not follow an idle cycle");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        dout[pkt_valid_pos] |=> !dout[pkt_valid_pos])
    else begin
        fail_count++;
        $error("a packet stayed on dout for more than one cycle");
    end

    assert property (@(posedge clk) disable iff (!rst_n) !$fell(overflow))
    else begin
        fail_count++;
        $error("overflow fell without a reset");
    end

endmodule

// ==== verif/leaf_node_tb.sv ====
`timescale 1ns/1ns
module leaf_node_tb
    import leaf_pkg::*;
();

    localparam int          fifo_depth = 8;
    localparam int          start_hold = 4;
    localparam logic [31:0] lfsr_taps  = 32'h8020_0003;

    logic                   clk;
    logic                   rst_n;
    logic [packet_bits-1:0] din;
    logic [packet_bits-1:0] dout;
    logic                   resend;
    logic                   ap_start;
    logic                   overflow;
    logic                   kernel_held;
    logic [31:0]            lfsr;
    logic [packet_bits-1:0] sum_q [$];  // predicted packets of output stream 0
    logic [packet_bits-1:0] xor_q [$];
    logic [packet_bits-1:0] exp_head [2];
    logic [packet_bits-1:0] exp_pkt;
    logic [leaf_bits-1:0]   dest_leaf [2];
    logic [port_bits-1:0]   dest_port [2];
    string                  test_name;
    int                     errors;
    int                     tests_run;
    int                     failed_tests;

    tb_clock clock_inst (.clk(clk));

    leaf_node #(
        .fifo_depth (fifo_depth),
        .start_hold (start_hold)
    ) leaf_node_inst (.*);

    bind leaf_node leaf_node_asserts asserts_inst (.clk, .rst_n, .dout, .resend, .overflow);

    // the two streams go to different leaves, so the leaf field tells them apart
    assign exp_pkt = (dout[leaf_hi:leaf_lo] == dest_leaf[1]) ? exp_head[1] : exp_head[0];

    assert property (@(posedge clk) disable iff (!rst_n)
        dout[pkt_valid_pos] |-> exp_pkt[pkt_valid_pos])
    else begin
        errors++;
        $display("test %s: a packet left the node with none predicted", test_name);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        dout[pkt_valid_pos] && exp_pkt[pkt_valid_pos] |-> dout == exp_pkt)
    else begin
        errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", test_name,
                 $sampled(exp_pkt), $sampled(dout));
    end

    assert property (@(posedge clk) disable iff (!rst_n) kernel_held |-> !dout[pkt_valid_pos])
    else begin
        errors++;
        $display("test %s: a packet left the node while the kernel was held", test_name);
    end

    always @(posedge clk) begin
        if (rst_n && dout[pkt_valid_pos]) begin
            if (dout[leaf_hi:leaf_lo] == dest_leaf[1] && xor_q.size() > 0) begin
                void'(xor_q.pop_front());
            end else if (dout[leaf_hi:leaf_lo] != dest_leaf[1] && sum_q.size() > 0) begin
                void'(sum_q.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        exp_head[0] = (sum_q.size() > 0) ? sum_q[0] : '0;
        exp_head[1] = (xor_q.size() > 0) ? xor_q[0] : '0;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            word = {word[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return word;
    endfunction

    function automatic int total_errors();
        return errors + leaf_node_inst.asserts_inst.fail_count;
    endfunction

    function automatic logic [packet_bits-1:0] predict(input logic stream, input logic [31:0] value);
        logic [packet_bits-1:0] pkt;
        pkt                        = '0;
        pkt[pkt_valid_pos]         = 1'b1;
        pkt[leaf_hi:leaf_lo]       = dest_leaf[stream];
        pkt[port_hi:port_lo]       = dest_port[stream];
        pkt[payload_hi:payload_lo] = value;  // address field stays zero
        return pkt;
    endfunction

    task automatic send_packet(input logic [port_bits-1:0] port, input logic [31:0] payload);
        @(negedge clk);
        din                        = '0;
        din[pkt_valid_pos]         = 1'b1;
        din[port_hi:port_lo]       = port;
        din[payload_hi:payload_lo] = payload;
        @(negedge clk);
        din = '0;
    endtask

    task automatic configure(input logic sel, input logic [4:0] leaf, input logic [3:0] port);
        logic [31:0] payload;
        payload                          = '0;
        payload[cfg_op_hi:cfg_op_lo]     = cfg_set_dest;
        payload[cfg_sel_pos]             = sel;
        payload[cfg_leaf_hi:cfg_leaf_lo] = leaf;
        payload[cfg_port_hi:cfg_port_lo] = port;
        dest_leaf[sel] = leaf;
        dest_port[sel] = port;
        send_packet('0, payload);
    endtask

    // stream 0 adds the words on ports 1 and 2, stream 1 xors ports 3 and 4
    task automatic send_pair(input logic stream);
        logic [31:0] a;
        logic [31:0] b;
        a = random_word();
        b = random_word();
        if (stream == 1'b0) begin
            sum_q.push_back(predict(1'b0, a + b));
        end else begin
            xor_q.push_back(predict(1'b1, a ^ b));
        end
        send_packet(port_bits'(2 * stream + 1), a);
        send_packet(port_bits'(2 * stream + 2), b);
    endtask

    task automatic pulse_start();
        @(negedge clk);
        ap_start    = 1'b1;
        kernel_held = 1'b0;
        @(negedge clk);
        ap_start = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n       = 1'b0;
        kernel_held = 1'b1;
        sum_q.delete();
        xor_q.delete();
        dest_leaf = '{default: '0};
        dest_port = '{default: '0};
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (sum_q.size() + xor_q.size() > 0 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (sum_q.size() + xor_q.size() > 0) begin
            errors++;
            $display("test %s: timed out with %0d packets still expected", test_name,
                     sum_q.size() + xor_q.size());
        end
    endtask

    task automatic finish_test(input int mark);
        tests_run++;
        if (total_errors() == mark) begin
            $display("test %s: passed", test_name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", test_name, total_errors() - mark);
        end
    endtask

    initial begin
        int          mark;
        int          cycles;
        logic [31:0] word;
        logic [31:0] held [$];
        rst_n        = 1'b0;
        din          = '0;
        resend       = 1'b0;
        ap_start     = 1'b0;
        kernel_held  = 1'b1;
        lfsr         = 32'h8e82d74d;
        errors       = 0;
        tests_run    = 0;
        failed_tests = 0;
        apply_reset();

        test_name = "sum_stream";
        mark      = total_errors();
        configure(1'b0, 5'd3, 4'd2);
        pulse_start();
        repeat (6) send_pair(1'b0);
        wait_drain(200);
        finish_test(mark);

        test_name = "xor_mixed";
        mark      = total_errors();
        configure(1'b1, 5'd9, 4'd5);
        for (int i = 0; i < 6; i++) begin
            send_pair(1'b1);
            send_pair(1'b0);
        end
        wait_drain(300);
        finish_test(mark);

        test_name = "resend";
        mark      = total_errors();
        fork
            repeat (5) begin
                send_pair(1'b0);
                send_pair(1'b1);
            end
            begin
                repeat (12) @(negedge clk);
                resend = 1'b1;
                repeat (15) @(negedge clk);
                resend = 1'b0;
            end
        join
        wait_drain(300);
        finish_test(mark);

        apply_reset();
        test_name = "start_hold";
        mark      = total_errors();
        configure(1'b0, 5'd3, 4'd2);
        repeat (3) send_pair(1'b0);
        repeat (20) @(negedge clk);  // buffered pairs must wait for ap_start
        pulse_start();
        wait_drain(200);
        finish_test(mark);

        apply_reset();
        test_name = "overflow";
        mark      = total_errors();
        configure(1'b0, 5'd3, 4'd2);
        for (int i = 0; i < fifo_depth + 2; i++) begin
            word = random_word();
            if (i < fifo_depth) begin
                held.push_back(word);  // the last two words are dropped by the full buffer
            end
            send_packet(4'd1, word);
        end
        cycles = 0;
        while (!overflow && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!overflow) begin
            errors++;
            $display("test %s: overflow never rose after the buffer filled", test_name);
        end
        pulse_start();
        for (int i = 0; i < fifo_depth + 2; i++) begin
            word = random_word();
            if (i < held.size()) begin
                sum_q.push_back(predict(1'b0, held[i] + word));
            end
            send_packet(4'd2, word);  // the last two partners have no word left to pair with
        end
        wait_drain(200);
        repeat (20) @(negedge clk);  // a surplus sum would show up as unpredicted
        finish_test(mark);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, failed_tests,
                 total_errors());
        if (total_errors() == 0 && failed_tests == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ns
module tb_clock #(
    parameter int period = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2);
            clk = ~clk;
        end
    end

endmodule
